//--- filelist.f
design/dcache_pkg.sv
design/dcache_ctrl.sv
design/dcache_tag_store.sv
design/dcache_data_store.sv
design/dcache_top.sv
test/tb_mem_model.sv
test/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# Build the data cache testbench with Verilator and run it.
# Exit status is 0 only when the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
	-f filelist.f \
	--top-module tb_dcache \
	-o sim_dcache
if [ $? -ne 0 ]; then
	echo "run_sim: verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_dcache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "run_sim: simulator exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^SIMULATION PASSED$"; then
	exit 0
fi
echo "run_sim: pass message not found in output"
exit 1

//--- test/tb_dcache.sv
// cache testbench; word addresses kept inside 32 lines so that all sets see evictions
`timescale 1ns/100ps

module tb_dcache;
	import dcache_pkg::*;

	localparam int          SET_BITS     = 2;
	localparam int          CLK_PERIOD   = 8;
	localparam int          RESET_CYCLES = 16;
	localparam int          NUM_REQUESTS = 2000;
	localparam int          LINES        = 32;
	localparam int          TEST_WORDS   = LINES * WORDS_PER_LINE;
	localparam int          TIMEOUT_NS   = (NUM_REQUESTS * 30 + RESET_CYCLES) * CLK_PERIOD;
	localparam logic [31:0] SEED         = 32'h785082b1;
	localparam word_t       FILL_KEY     = 32'h5a3c_0f96;

	logic       clk;
	logic       proc_reset;
	logic       proc_read;
	logic       proc_write;
	word_addr_t proc_addr;
	word_t      proc_wdata;
	word_t      proc_rdata;
	logic       proc_stall;
	logic       mem_read;
	logic       mem_write;
	line_addr_t mem_addr;
	line_t      mem_wdata;
	line_t      mem_rdata;
	logic       mem_ready;

	// expected contents of every word in the test range
	word_t model [TEST_WORDS];

	int mismatch_count = 0;
	int protocol_count = 0;
	int issued = 0;

	dcache_top #(
		.SET_BITS (SET_BITS)
	) i_dut (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	tb_mem_model #(
		.LINES    (LINES),
		.FILL_KEY (FILL_KEY)
	) i_mem (
		.clk        (clk),
		.proc_reset (proc_reset),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// processor side
	// ------------------------------------------------------------------------

	// one request, held until a rising edge sees proc_stall low
	task automatic access_word(input logic is_write, input int addr, input word_t data);
		@(negedge clk);
		proc_read  = ~is_write;
		proc_write = is_write;
		proc_addr  = word_addr_t'(addr);
		proc_wdata = data;
		do begin
			@(posedge clk);
		end while (proc_stall);
		if (is_write) begin
			model[addr] = data;
		end else if (proc_rdata !== model[addr]) begin
			mismatch_count++;
			$display("mismatch at %0t: read of word %0h gave %h, expected %h",
				$time, addr, proc_rdata, model[addr]);
		end
		issued++;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		proc_read  = 1'b0;
		proc_write = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// memory port monitor
	// ------------------------------------------------------------------------

	logic       pending = 1'b0;
	logic       held_read;
	logic       held_write;
	line_addr_t held_addr;
	line_t      held_wdata;

	always @(posedge clk) begin
		if (!proc_reset) begin
			if (mem_read && mem_write) begin
				protocol_count++;
				$display("protocol error at %0t: mem_read and mem_write both high", $time);
			end
			if (pending && (mem_read !== held_read || mem_write !== held_write ||
					mem_addr !== held_addr || (mem_write && mem_wdata !== held_wdata))) begin
				protocol_count++;
				$display("protocol error at %0t: memory request changed before mem_ready", $time);
			end
			// the processor holds its access through a stall, so a request always has one
			if ((mem_read || mem_write) && !proc_read && !proc_write) begin
				protocol_count++;
				$display("protocol error at %0t: memory request with no processor access", $time);
			end
			if ((mem_read || mem_write) && int'(mem_addr) >= LINES) begin
				protocol_count++;
				$display("protocol error at %0t: line %0h is outside the test range",
					$time, mem_addr);
			end else if (mem_write && mem_ready) begin
				// evicted dirty line must carry the latest value of every word
				for (int w = 0; w < WORDS_PER_LINE; w++) begin
					if (mem_wdata[w*WORD_BITS +: WORD_BITS] !==
							model[int'(mem_addr) * WORDS_PER_LINE + w]) begin
						mismatch_count++;
						$display("mismatch at %0t: write-back of line %0h word %0d gave %h",
							$time, mem_addr, w, mem_wdata[w*WORD_BITS +: WORD_BITS]);
					end
				end
			end
			pending    = (mem_read || mem_write) && !mem_ready;
			held_read  = mem_read;
			held_write = mem_write;
			held_addr  = mem_addr;
			held_wdata = mem_wdata;
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: requests stopped completing after %0d of %0d", issued, NUM_REQUESTS);
		$display("SIMULATION FAILED");
		$finish;
	end

	// ------------------------------------------------------------------------
	// sequence
	// ------------------------------------------------------------------------

	initial begin
		void'($urandom(SEED));
		proc_reset = 1'b1;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		for (int a = 0; a < TEST_WORDS; a++) begin
			model[a] = word_t'(a) ^ FILL_KEY;
		end
		repeat (RESET_CYCLES) @(negedge clk);
		proc_reset = 1'b0;

		// cold misses, then hits on the same words
		access_word(1'b0, 0, '0);
		access_word(1'b0, 5, '0);
		access_word(1'b0, 0, '0);
		access_word(1'b0, 5, '0);
		access_word(1'b0, 77, '0);

		// write one word, the rest of the line is untouched
		access_word(1'b1, 9, 32'hcafe_0009);
		for (int a = 8; a < 12; a++) begin
			access_word(1'b0, a, '0);
		end

		// lines 0, 4, 8 all map to set 0, so the third write evicts line 0 dirty
		access_word(1'b1, 0, 32'h1111_0000);
		access_word(1'b1, 16, 32'h2222_0010);
		access_word(1'b1, 32, 32'h3333_0020);
		access_word(1'b0, 0, '0);
		access_word(1'b0, 16, '0);
		access_word(1'b0, 32, '0);
		access_word(1'b0, 48, '0);

		// random mix of reads, writes and gaps
		while (issued < NUM_REQUESTS) begin
			access_word($urandom_range(1, 0) == 1, int'($urandom_range(TEST_WORDS - 1, 0)),
				$urandom);
			if ($urandom_range(3, 0) == 0) begin
				idle_cycle();
			end
		end
		idle_cycle();
		repeat (4) @(negedge clk);

		$display("done: %0d requests, %0d mismatches, %0d protocol errors",
			issued, mismatch_count, protocol_count);
		if (mismatch_count == 0 && protocol_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- test/tb_mem_model.sv
// line memory for the testbench; only the low LINES line addresses are backed, latency 1 to 8
`timescale 1ns/100ps

module tb_mem_model #(
	parameter int                LINES    = 32,
	parameter dcache_pkg::word_t FILL_KEY = 32'h5a3c_0f96
) (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  logic                   mem_read,
	input  logic                   mem_write,
	input  dcache_pkg::line_addr_t mem_addr,
	input  dcache_pkg::line_t      mem_wdata,
	output dcache_pkg::line_t      mem_rdata,
	output logic                   mem_ready
);
	import dcache_pkg::*;

	localparam int IDX_BITS = $clog2(LINES);

	line_t lines [LINES];

	// outputs start low before the first falling edge
	logic  ready_q = 1'b0;
	line_t rdata_q = '0;

	// waiting on a request, and cycles still to go
	logic counting = 1'b0;
	int   remain = 0;

	logic [IDX_BITS-1:0] idx;

	assign idx       = mem_addr[IDX_BITS-1:0];
	assign mem_ready = ready_q;
	assign mem_rdata = rdata_q;

	// everything moves on the falling edge, away from the cache's rising edge
	always @(negedge clk) begin
		if (proc_reset) begin
			// each word holds its own word address mixed with the key
			for (int l = 0; l < LINES; l++) begin
				for (int w = 0; w < WORDS_PER_LINE; w++) begin
					lines[l][w*WORD_BITS +: WORD_BITS] = word_t'(l * WORDS_PER_LINE + w) ^ FILL_KEY;
				end
			end
			ready_q  = 1'b0;
			rdata_q  = '0;
			counting = 1'b0;
		end else if (ready_q) begin
			// transfer closed at the last rising edge
			ready_q = 1'b0;
		end else if (mem_read || mem_write) begin
			if (!counting) begin
				counting = 1'b1;
				remain   = int'($urandom_range(7, 0));
			end
			if (remain == 0) begin
				// request is still held here, so wdata is the victim line
				counting = 1'b0;
				ready_q  = 1'b1;
				if (mem_write) begin
					lines[idx] = mem_wdata;
				end else begin
					rdata_q = lines[idx];
				end
			end else begin
				remain--;
			end
		end
	end

endmodule

//--- design/dcache_top.sv
// write-back cache top; requests held under stall on both sides, SET_BITS from 1 to 4
`timescale 1ns/100ps

module dcache_top #(
	parameter int SET_BITS = 2
) (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  logic                   proc_read,
	input  logic                   proc_write,
	input  dcache_pkg::word_addr_t proc_addr,
	input  dcache_pkg::word_t      proc_wdata,
	output dcache_pkg::word_t      proc_rdata,
	output logic                   proc_stall,
	output logic                   mem_read,
	output logic                   mem_write,
	output dcache_pkg::line_addr_t mem_addr,
	output dcache_pkg::line_t      mem_wdata,
	input  dcache_pkg::line_t      mem_rdata,
	input  logic                   mem_ready
);
	import dcache_pkg::*;

	// tag store to controller
	logic       hit;
	logic       victim_dirty;
	line_addr_t victim_line_addr;

	// tag store to data store
	logic hit_way;
	logic victim_way;

	// controller to both stores
	logic word_write;
	logic refill;
	logic clean;

	// ------------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------------

	dcache_ctrl i_ctrl (
		.clk              (clk),
		.proc_reset       (proc_reset),
		.proc_read        (proc_read),
		.proc_write       (proc_write),
		.proc_addr        (proc_addr),
		.hit              (hit),
		.victim_dirty     (victim_dirty),
		.victim_line_addr (victim_line_addr),
		.mem_ready        (mem_ready),
		.proc_stall       (proc_stall),
		.mem_read         (mem_read),
		.mem_write        (mem_write),
		.mem_addr         (mem_addr),
		.word_write       (word_write),
		.refill           (refill),
		.clean            (clean)
	);

	// ------------------------------------------------------------------------
	// stores
	// ------------------------------------------------------------------------

	dcache_tag_store #(
		.SET_BITS (SET_BITS)
	) i_tag_store (
		.clk              (clk),
		.proc_reset       (proc_reset),
		.proc_addr        (proc_addr),
		.word_write       (word_write),
		.refill           (refill),
		.clean            (clean),
		.hit              (hit),
		.hit_way          (hit_way),
		.victim_way       (victim_way),
		.victim_dirty     (victim_dirty),
		.victim_line_addr (victim_line_addr)
	);

	dcache_data_store #(
		.SET_BITS (SET_BITS)
	) i_data_store (
		.clk        (clk),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.mem_rdata  (mem_rdata),
		.hit_way    (hit_way),
		.victim_way (victim_way),
		.word_write (word_write),
		.refill     (refill),
		.proc_rdata (proc_rdata),
		.mem_wdata  (mem_wdata)
	);

endmodule

//--- design/dcache_data_store.sv
// line storage for two ways; reads combinational, writes on the enable edge, no reset on data
`timescale 1ns/100ps

module dcache_data_store #(
	parameter int SET_BITS = 2
) (
	input  logic                   clk,
	input  dcache_pkg::word_addr_t proc_addr,
	input  dcache_pkg::word_t      proc_wdata,
	input  dcache_pkg::line_t      mem_rdata,
	input  logic                   hit_way,
	input  logic                   victim_way,
	input  logic                   word_write,
	input  logic                   refill,
	output dcache_pkg::word_t      proc_rdata,
	output dcache_pkg::line_t      mem_wdata
);
	import dcache_pkg::*;

	localparam int SETS = 1 << SET_BITS;

	typedef logic [SET_BITS-1:0]    set_t;
	typedef logic [OFFSET_BITS-1:0] offset_t;

	line_t data_q [2][SETS];

	set_t    set_idx;
	offset_t word_sel;
	line_t   hit_line;
	line_t   merged_line;
	line_t   write_line;
	logic    write_way;

	assign set_idx  = proc_addr[OFFSET_BITS+SET_BITS-1:OFFSET_BITS];
	assign word_sel = proc_addr[OFFSET_BITS-1:0];
	assign hit_line = data_q[hit_way][set_idx];

	// whole victim line for the write-back
	assign mem_wdata = data_q[victim_way][set_idx];

	// pick the addressed word, and splice in the write data
	always_comb begin
		proc_rdata  = '0;
		merged_line = hit_line;
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			if (word_sel == offset_t'(w)) begin
				proc_rdata = hit_line[w*WORD_BITS +: WORD_BITS];
				merged_line[w*WORD_BITS +: WORD_BITS] = proc_wdata;
			end
		end
	end

	// refill lands in the victim way, a write hit in the hit way
	assign write_way  = refill ? victim_way : hit_way;
	assign write_line = refill ? mem_rdata : merged_line;

	always_ff @(posedge clk) begin
		if (word_write || refill) begin
			data_q[write_way][set_idx] <= write_line;
		end
	end

endmodule

//--- design/dcache_tag_store.sv
// two ways per set; SET_BITS from 1 to 4; outputs are combinational from proc_addr
`timescale 1ns/100ps

module dcache_tag_store #(
	parameter int SET_BITS = 2
) (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  dcache_pkg::word_addr_t proc_addr,
	input  logic                   word_write,
	input  logic                   refill,
	input  logic                   clean,
	output logic                   hit,
	output logic                   hit_way,
	output logic                   victim_way,
	output logic                   victim_dirty,
	output dcache_pkg::line_addr_t victim_line_addr
);
	import dcache_pkg::*;

	localparam int SETS     = 1 << SET_BITS;
	localparam int TAG_BITS = $bits(line_addr_t) - SET_BITS;

	typedef logic [SET_BITS-1:0] set_t;
	typedef logic [TAG_BITS-1:0] tag_t;

	// per set, bit w belongs to way w
	logic [1:0] valid_q [SETS];
	logic [1:0] dirty_q [SETS];

	// way to evict next when both are valid
	logic repl_q [SETS];

	tag_t tag_q [2][SETS];

	line_addr_t req_line;
	set_t       set_idx;
	tag_t       req_tag;
	logic [1:0] way_hit;

	// set from the low line bits, tag from the rest
	assign req_line = proc_addr[$bits(word_addr_t)-1:OFFSET_BITS];
	assign set_idx  = req_line[SET_BITS-1:0];
	assign req_tag  = req_line[$bits(line_addr_t)-1:SET_BITS];

	// ------------------------------------------------------------------------
	// lookup
	// ------------------------------------------------------------------------

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[set_idx][w] && (tag_q[w][set_idx] == req_tag);
		end
	end

	assign hit     = |way_hit;
	assign hit_way = way_hit[1];

	// empty ways first, way 0 before way 1
	always_comb begin
		if (!valid_q[set_idx][0]) begin
			victim_way = 1'b0;
		end else if (!valid_q[set_idx][1]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = repl_q[set_idx];
		end
	end

	assign victim_dirty     = dirty_q[set_idx][victim_way];
	assign victim_line_addr = {tag_q[victim_way][set_idx], set_idx};

	// ------------------------------------------------------------------------
	// updates
	// ------------------------------------------------------------------------

	// the three pulses come from different states, never together
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
				repl_q[s]  <= 1'b0;
			end
		end else if (refill) begin
			// fresh line is clean, the other way goes next
			valid_q[set_idx][victim_way] <= 1'b1;
			dirty_q[set_idx][victim_way] <= 1'b0;
			repl_q[set_idx]              <= ~victim_way;
		end else if (clean) begin
			dirty_q[set_idx][victim_way] <= 1'b0;
		end else if (word_write) begin
			dirty_q[set_idx][hit_way] <= 1'b1;
		end
	end

	// tags only change with a refill
	always_ff @(posedge clk) begin
		if (refill) begin
			tag_q[victim_way][set_idx] <= req_tag;
		end
	end

endmodule

//--- design/dcache_ctrl.sv
// processor must hold its request while proc_stall is high; memory holds nothing between requests
`timescale 1ns/100ps

module dcache_ctrl (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  logic                   proc_read,
	input  logic                   proc_write,
	input  dcache_pkg::word_addr_t proc_addr,
	input  logic                   hit,
	input  logic                   victim_dirty,
	input  dcache_pkg::line_addr_t victim_line_addr,
	input  logic                   mem_ready,
	output logic                   proc_stall,
	output logic                   mem_read,
	output logic                   mem_write,
	output dcache_pkg::line_addr_t mem_addr,
	output logic                   word_write,
	output logic                   refill,
	output logic                   clean
);
	import dcache_pkg::*;

	cache_state_e state_q;
	cache_state_e state_d;

	// any processor request this cycle
	logic access;

	// line the processor is asking for
	line_addr_t req_line;

	assign access   = proc_read | proc_write;
	assign req_line = proc_addr[$bits(word_addr_t)-1:OFFSET_BITS];

	// ------------------------------------------------------------------------
	// state register
	// ------------------------------------------------------------------------

	// out of reset straight into tag compare
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= compare_tag;
		end else begin
			state_q <= state_d;
		end
	end

	// ------------------------------------------------------------------------
	// next state and outputs
	// ------------------------------------------------------------------------

	always_comb begin
		state_d    = state_q;
		proc_stall = 1'b1;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_addr   = req_line;
		word_write = 1'b0;
		refill     = 1'b0;
		clean      = 1'b0;
		case (state_q)
			compare_tag: begin
				// hits finish here with no extra cycle
				proc_stall = access & ~hit;
				word_write = proc_write & hit;
				if (access && !hit) begin
					// dirty victim must go out before the refill
					state_d = victim_dirty ? write_back : allocate;
				end
			end
			write_back: begin
				// victim address rebuilt by the tag store
				mem_write = 1'b1;
				mem_addr  = victim_line_addr;
				clean     = mem_ready;
				if (mem_ready) begin
					state_d = allocate;
				end
			end
			allocate: begin
				// request stays up through the ready cycle
				mem_read = 1'b1;
				refill   = mem_ready;
				if (mem_ready) begin
					// back to compare, where the access now hits
					state_d = compare_tag;
				end
			end
			default: begin
				state_d = compare_tag;
			end
		endcase
	end

endmodule

//--- design/dcache_pkg.sv
// assumes a 32-bit word-addressed processor and 4-word lines; set count is a module parameter
package dcache_pkg;

	// ------------------------------------------------------------------------
	// basic widths
	// ------------------------------------------------------------------------

	// processor data word
	localparam int WORD_BITS = 32;

	// word offset inside a line
	localparam int OFFSET_BITS = 2;
	localparam int WORDS_PER_LINE = 1 << OFFSET_BITS;

	// processor word address, byte offset already stripped
	localparam int WORD_ADDR_BITS = 30;

	typedef logic [WORD_BITS-1:0] word_t;

	// word 0 sits in the low bits
	typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] line_t;

	typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;

	// word address without its offset, as seen by memory
	typedef logic [WORD_ADDR_BITS-OFFSET_BITS-1:0] line_addr_t;

	// ------------------------------------------------------------------------
	// controller states
	// ------------------------------------------------------------------------

	// compare_tag serves hits and spots misses
	// write_back pushes the dirty victim out
	// allocate fetches the missing line
	typedef enum logic [1:0] {
		compare_tag = 2'd0,
		write_back  = 2'd1,
		allocate    = 2'd2
	} cache_state_e;

endpackage
